/* hdl/controller.sv */
// RV32I pipelined controller
`timescale 1ns/1ps
`default_nettype none

module controller import rvPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  instr_t     instrD,                   // Instruction in Decode
  input  logic       stallD, stallE, stallM, stallW,
  input  logic       flushD, flushE, flushM, flushW,
  input  logic [1:0] flagsE,                   // Comparator flags {eq, lt}
  output immSrc_t    immSrcD,                  // Immediate format for Decode
  output ctrlE_t     ctrlE,
  output ctrlM_t     ctrlM,
  output ctrlW_t     ctrlW,
  output logic       pcSrcE,                   // Fetch from target next
  output logic       branchSignedE             // Signed compare
);

  logic [6:0] opD;
  logic [2:0] funct3D;
  logic [6:0] funct7D;
  logic       validD;                          // Decode holds a fetched word
  logic       legalD;                          // Encoding implemented
  ctrlE_t     decD;                            // Raw decoder output
  ctrlE_t     ctrlD;                           // Squashed Decode bundle
  logic       branchFlagE;
  logic       takenE;

  // funct3 plus funct7[5] to ALU op, sub only for R-type
  function automatic aluOp_t aluDecode(input logic [2:0] f3, input logic alt,
                                       input logic rType);
    case (f3)
      3'b000:  aluDecode = (alt & rType) ? aluSub : aluAdd;
      3'b001:  aluDecode = aluSll;
      3'b010:  aluDecode = aluSlt;
      3'b011:  aluDecode = aluSltu;
      3'b100:  aluDecode = aluXor;
      3'b101:  aluDecode = alt ? aluSra : aluSrl;
      3'b110:  aluDecode = aluOr;
      default: aluDecode = aluAnd;
    endcase
  endfunction

  assign opD     = instrD[6:0];
  assign funct3D = instrD[14:12];
  assign funct7D = instrD[31:25];

  ////////////////////
  // Main decoder
  ////////////////////

  always_comb begin
    decD    = '0;
    legalD  = 1'b1;
    immSrcD = immI;
    case (opD)
      7'b0110011: begin                        // R-type
        decD.regWrite = 1'b1;
        decD.aluOp    = aluDecode(funct3D, funct7D[5], 1'b1);
        legalD        = (funct7D == 7'h00) |
                        ((funct7D == 7'h20) & (funct3D == 3'b000 | funct3D == 3'b101));
      end
      7'b0010011: begin                        // I-type ALU
        decD.regWrite = 1'b1;
        decD.aluSrcB  = 1'b1;
        decD.aluOp    = aluDecode(funct3D, funct7D[5], 1'b0);
        // Shift amounts carry a fixed funct7
        legalD        = (funct3D[1:0] != 2'b01) |
                        (funct7D == {1'b0, funct3D[2] & funct7D[5], 5'b0});
      end
      7'b0000011: begin                        // lw
        decD.regWrite  = 1'b1;
        decD.resultSrc = resMem;
        decD.memRead   = 1'b1;
        decD.aluSrcB   = 1'b1;
        legalD         = (funct3D == 3'b010);
      end
      7'b0100011: begin                        // sw
        decD.memWrite = 1'b1;
        decD.aluSrcB  = 1'b1;
        immSrcD       = immS;
        legalD        = (funct3D == 3'b010);
      end
      7'b1100011: begin                        // Branches
        decD.branch = 1'b1;
        immSrcD     = immB;
        legalD      = (funct3D[2:1] != 2'b01);
      end
      7'b1101111: begin                        // jal
        decD.regWrite  = 1'b1;
        decD.resultSrc = resPc4;
        decD.jump      = 1'b1;
        immSrcD        = immJ;
      end
      7'b1100111: begin                        // jalr, target from ALU
        decD.regWrite  = 1'b1;
        decD.resultSrc = resPc4;
        decD.jump      = 1'b1;
        decD.jumpReg   = 1'b1;
        decD.aluSrcB   = 1'b1;
        legalD         = (funct3D == 3'b000);
      end
      7'b0110111: begin                        // lui
        decD.regWrite = 1'b1;
        decD.aluSrcB  = 1'b1;
        decD.aluOp    = aluPassB;
        immSrcD       = immU;
      end
      7'b0010111: begin                        // auipc
        decD.regWrite = 1'b1;
        decD.aluSrcA  = 1'b1;
        decD.aluSrcB  = 1'b1;
        immSrcD       = immU;
      end
      default: legalD = 1'b0;
    endcase
  end

  // Illegal or empty slot keeps no side effects
  always_comb begin
    ctrlD = '0;
    if (validD && legalD) begin
      ctrlD        = decD;
      ctrlD.funct3 = funct3D;
    end
    ctrlD.instrValid = validD;
    ctrlD.illegal    = validD & ~legalD;
  end

  ////////////////////
  // Stage registers
  ////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validD <= 1'b0;
      ctrlE  <= '0;
      ctrlM  <= '0;
      ctrlW  <= '0;
    end else begin
      if (flushD) validD <= 1'b0;
      else if (!stallD) validD <= 1'b1;

      if (flushE) ctrlE <= '0;
      else if (!stallE) ctrlE <= ctrlD;

      if (flushM) begin
        ctrlM <= '0;
      end else if (!stallM) begin
        ctrlM <= '{regWrite: ctrlE.regWrite, resultSrc: ctrlE.resultSrc,
                   memRead: ctrlE.memRead, memWrite: ctrlE.memWrite,
                   instrValid: ctrlE.instrValid, illegal: ctrlE.illegal};
      end

      if (flushW) ctrlW <= '0;
      else if (!stallW) ctrlW <= '{regWrite: ctrlM.regWrite, resultSrc: ctrlM.resultSrc};
    end
  end

  // Branch decision; bltu and bgeu compare unsigned
  assign branchSignedE = (ctrlE.funct3[2:1] != 2'b11);
  assign branchFlagE   = ctrlE.funct3[2] ? flagsE[0] : flagsE[1];
  assign takenE        = branchFlagE ^ ctrlE.funct3[0];   // bne, bge, bgeu invert
  assign pcSrcE        = ctrlE.jump | (ctrlE.branch & takenE);

endmodule

`default_nettype wire

/* hdl/datapath.sv */
// RV32I pipelined datapath
`timescale 1ns/1ps
`default_nettype none

module datapath import rvPkg::*; #(
  parameter word_t resetVector = '0            // First fetch address
) (
  input  logic       clk,
  input  logic       arstN,
  input  logic       stallF, stallD, stallE, stallM, stallW,
  input  logic       flushD, flushE, flushM, flushW,
  input  immSrc_t    immSrcD,
  input  ctrlE_t     ctrlE,
  input  ctrlW_t     ctrlW,
  input  logic       pcSrcE,
  input  logic       branchSignedE,
  input  fwdSel_t    forwardAE, forwardBE,
  output word_t      instrAdr,                 // Fetch address
  input  instr_t     instr,                    // Fetched word, same cycle
  output instr_t     instrD,
  output logic [1:0] flagsE,                   // {eq, lt}
  output regAdr_t    rs1D, rs2D, rs1E, rs2E,
  output regAdr_t    rdE, rdM, rdW,
  output word_t      aluResultM,
  output word_t      writeDataM,               // Store data
  input  word_t      readDataW                 // Load data
);

  word_t   pcF, pc4F, pcNextF;
  word_t   pcD, pc4D, immExtD, rd1D, rd2D;
  word_t   pcE, pc4E, immE, rd1E, rd2E;
  word_t   srcAE, srcBE, fwdAE, fwdBE, aluResultE, pcTargetE;
  word_t   pc4M, aluResultW, pc4W, resultW;

  function automatic word_t fwdMux(input fwdSel_t sel, input word_t regVal,
                                   input word_t memVal, input word_t wbVal);
    case (sel)
      fwdM:    fwdMux = memVal;
      fwdW:    fwdMux = wbVal;
      default: fwdMux = regVal;
    endcase
  endfunction

  ////////////////////
  // Fetch
  ////////////////////

  assign pc4F     = pcF + 32'd4;
  assign pcNextF  = pcSrcE ? pcTargetE : pc4F;
  assign instrAdr = pcF;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) pcF <= resetVector;
    else if (!stallF) pcF <= pcNextF;
  end

  ////////////////////
  // Decode
  ////////////////////

  always_ff @(posedge clk) begin
    if (flushD) begin
      instrD <= '0;                            // Zero fields, no false hazards
    end else if (!stallD) begin
      instrD <= instr;
      pcD    <= pcF;
      pc4D   <= pc4F;
    end
  end

  assign rs1D = instrD[19:15];
  assign rs2D = instrD[24:20];

  always_comb begin
    case (immSrcD)
      immS:    immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
      immB:    immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
      immJ:    immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
      immU:    immExtD = {instrD[31:12], 12'b0};
      default: immExtD = {{20{instrD[31]}}, instrD[31:20]};
    endcase
  end

  regFile regFile_i (
    .clk   (clk),
    .arstN (arstN),
    .we    (ctrlW.regWrite),
    .a1    (rs1D),
    .a2    (rs2D),
    .a3    (rdW),
    .wd    (resultW),
    .rd1   (rd1D),
    .rd2   (rd2D)
  );

  ////////////////////
  // Execute
  ////////////////////

  always_ff @(posedge clk) begin
    if (flushE) begin
      rs1E <= '0;
      rs2E <= '0;
      rdE  <= '0;
    end else if (!stallE) begin
      rd1E <= rd1D;
      rd2E <= rd2D;
      immE <= immExtD;
      pcE  <= pcD;
      pc4E <= pc4D;
      rs1E <= rs1D;
      rs2E <= rs2D;
      rdE  <= instrD[11:7];
    end
  end

  assign fwdAE = fwdMux(forwardAE, rd1E, aluResultM, resultW);
  assign fwdBE = fwdMux(forwardBE, rd2E, aluResultM, resultW);
  assign srcAE = ctrlE.aluSrcA ? pcE : fwdAE;
  assign srcBE = ctrlE.aluSrcB ? immE : fwdBE;

  always_comb begin
    case (ctrlE.aluOp)
      aluSub:   aluResultE = srcAE - srcBE;
      aluSll:   aluResultE = srcAE << srcBE[4:0];
      aluSlt:   aluResultE = {31'b0, $signed(srcAE) < $signed(srcBE)};
      aluSltu:  aluResultE = {31'b0, srcAE < srcBE};
      aluXor:   aluResultE = srcAE ^ srcBE;
      aluSrl:   aluResultE = srcAE >> srcBE[4:0];
      aluSra:   aluResultE = $signed(srcAE) >>> srcBE[4:0];
      aluOr:    aluResultE = srcAE | srcBE;
      aluAnd:   aluResultE = srcAE & srcBE;
      aluPassB: aluResultE = srcBE;            // lui
      default:  aluResultE = srcAE + srcBE;
    endcase
  end

  // Comparator on forwarded register values
  assign flagsE[1] = (fwdAE == fwdBE);
  assign flagsE[0] = branchSignedE ? ($signed(fwdAE) < $signed(fwdBE)) : (fwdAE < fwdBE);

  // jalr clears bit 0 of rs1 + imm
  assign pcTargetE = ctrlE.jumpReg ? {aluResultE[31:1], 1'b0} : pcE + immE;

  ////////////////////
  // Memory and Writeback
  ////////////////////

  always_ff @(posedge clk) begin
    if (flushM) begin
      rdM <= '0;
    end else if (!stallM) begin
      aluResultM <= aluResultE;
      writeDataM <= fwdBE;
      pc4M       <= pc4E;
      rdM        <= rdE;
    end
    if (flushW) begin
      rdW <= '0;
    end else if (!stallW) begin
      aluResultW <= aluResultM;
      pc4W       <= pc4M;
      rdW        <= rdM;
    end
  end

  always_comb begin
    case (ctrlW.resultSrc)
      resMem:  resultW = readDataW;
      resPc4:  resultW = pc4W;                 // Link value
      default: resultW = aluResultW;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/hazardUnit.sv */
// Pipeline hazard unit
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import rvPkg::*; (
  input  regAdr_t rs1D, rs2D, rs1E, rs2E,
  input  regAdr_t rdE, rdM, rdW,
  input  logic    memReadE,                    // Load in Execute
  input  logic    regWriteM, regWriteW,
  input  logic    pcSrcE,                      // Taken branch or jump
  input  logic    memBusyM,                    // Bus access pending
  output logic    stallF, stallD, stallE, stallM, stallW,
  output logic    flushD, flushE, flushM, flushW,
  output fwdSel_t forwardAE, forwardBE
);

  logic loadUseD;

  // Memory stage wins, it holds the younger result
  function automatic fwdSel_t fwdFor(input regAdr_t rs);
    if (rs == '0) fwdFor = fwdNone;
    else if (regWriteM && rs == rdM) fwdFor = fwdM;
    else if (regWriteW && rs == rdW) fwdFor = fwdW;
    else fwdFor = fwdNone;
  endfunction

  always_comb begin
    forwardAE = fwdFor(rs1E);
    forwardBE = fwdFor(rs2E);
  end

  assign loadUseD = memReadE & (rdE != '0) & ((rdE == rs1D) | (rdE == rs2D));

  // Bus freeze holds every stage and masks flushes
  assign stallF = loadUseD | memBusyM;
  assign stallD = loadUseD | memBusyM;
  assign stallE = memBusyM;
  assign stallM = memBusyM;
  assign stallW = memBusyM;

  assign flushD = pcSrcE & ~memBusyM;          // Wrong-path fetch
  assign flushE = (pcSrcE | loadUseD) & ~memBusyM;
  assign flushM = 1'b0;                        // No traps to squash M or W
  assign flushW = 1'b0;

endmodule

`default_nettype wire

/* hdl/ieuCore.sv */
// RV32I five-stage core
`timescale 1ns/1ps
`default_nettype none

module ieuCore import rvPkg::*; #(
  parameter word_t resetVector = '0            // Start address
) (
  input  logic   clk,
  input  logic   arstN,
  output word_t  instrAdr,                     // Instruction ROM address
  input  instr_t instr,                        // ROM data, same cycle
  output wbReq_t wbOut,                        // Data bus master side
  input  wbRsp_t wbIn,
  output logic   illegalInstr                  // Unimplemented opcode in M
);

  logic       stallF, stallD, stallE, stallM, stallW;
  logic       flushD, flushE, flushM, flushW;
  immSrc_t    immSrcD;
  ctrlE_t     ctrlE;
  ctrlM_t     ctrlM;
  ctrlW_t     ctrlW;
  logic       pcSrcE, branchSignedE;
  logic [1:0] flagsE;
  instr_t     instrD;
  regAdr_t    rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
  fwdSel_t    forwardAE, forwardBE;
  word_t      aluResultM, writeDataM, readDataW;
  logic       memBusyM;

  controller controller_i (.*);

  datapath #(
    .resetVector (resetVector)
  ) datapath_i (.*);

  hazardUnit hazardUnit_i (
    .memReadE  (ctrlE.memRead),
    .regWriteM (ctrlM.regWrite),
    .regWriteW (ctrlW.regWrite),
    .*
  );

  lsuWishbone lsuWishbone_i (.*);

  assign illegalInstr = ctrlM.illegal;         // Held while M is frozen

endmodule

`default_nettype wire

/* hdl/lsuWishbone.sv */
// Wishbone classic load/store unit
`timescale 1ns/1ps
`default_nettype none

module lsuWishbone import rvPkg::*; (
  input  logic   clk,
  input  logic   arstN,
  input  ctrlM_t ctrlM,                        // Memory-stage control
  input  word_t  aluResultM,                   // Byte address
  input  word_t  writeDataM,                   // Store data
  input  logic   stallW,                       // Later stages held
  output wbReq_t wbOut,
  input  wbRsp_t wbIn,
  output logic   memBusyM,                     // Freeze request
  output word_t  readDataW                     // Load data for Writeback
);

  typedef enum logic {lsIdle, lsWait} lsState_t;

  lsState_t state;
  logic     accessM;                           // Load or store in M
  logic     ackM;                              // Bus cycle ends this cycle
  logic     busCyc;

  assign accessM  = ctrlM.instrValid & (ctrlM.memRead | ctrlM.memWrite);
  assign ackM     = (state == lsWait) & wbIn.ack;
  assign memBusyM = accessM & ~ackM;           // Released in the ack cycle
  assign busCyc   = (state == lsWait);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= lsIdle;
    end else begin
      case (state)
        lsIdle:  if (accessM) state <= lsWait;
        lsWait:  if (wbIn.ack) state <= lsIdle;   // cyc drops next cycle
        default: state <= lsIdle;
      endcase
    end
  end

  // A load leaves M only in its ack cycle
  always_ff @(posedge clk) begin
    if (!stallW && ctrlM.memRead) readDataW <= wbIn.datR;
  end

  // M is frozen during the cycle, so address and data hold until ack
  assign wbOut = '{cyc: busCyc, stb: busCyc, we: ctrlM.memWrite,
                   adr: aluResultM, datW: writeDataM, sel: 4'hf};

endmodule

`default_nettype wire

/* hdl/regFile.sv */
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module regFile import rvPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    we,                          // Write enable from Writeback
  input  regAdr_t a1, a2,                      // Read addresses
  input  regAdr_t a3,                          // Write address
  input  word_t   wd,
  output word_t   rd1, rd2
);

  word_t regs [1:31];                          // x0 not stored

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (we && a3 != '0) begin
      regs[a3] <= wd;
    end
  end

  // Write-through so Decode sees this cycle's Writeback
  assign rd1 = (a1 == '0) ? '0 : (we && a1 == a3) ? wd : regs[a1];
  assign rd2 = (a2 == '0) ? '0 : (we && a2 == a3) ? wd : regs[a2];

endmodule

`default_nettype wire

/* hdl/rvPkg.sv */
// RV32I core shared types
`default_nettype none

package rvPkg;

  localparam int xlenW = 32;                   // Data path width

  typedef logic [xlenW-1:0] word_t;            // Data word
  typedef logic [31:0]      instr_t;           // Instruction word
  typedef logic [4:0]       regAdr_t;          // Register index

  // Immediate formats
  typedef enum logic [2:0] {
    immI, immS, immB, immJ, immU
  } immSrc_t;

  // ALU operations, add first so a cleared bundle means add
  typedef enum logic [3:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
    aluSrl, aluSra, aluOr, aluAnd, aluPassB
  } aluOp_t;

  typedef enum logic [1:0] {
    resAlu, resMem, resPc4
  } resultSrc_t;                               // Writeback source

  typedef enum logic [1:0] {
    fwdNone, fwdW, fwdM
  } fwdSel_t;                                  // Operand forwarding

  ////////////////////
  // Control bundles
  ////////////////////

  typedef struct packed {
    logic       regWrite;
    resultSrc_t resultSrc;
    logic       memRead;
    logic       memWrite;
    logic       jump;                          // jal or jalr
    logic       branch;
    logic       jumpReg;                       // jalr target from rs1
    aluOp_t     aluOp;
    logic       aluSrcA;                       // A operand is pc
    logic       aluSrcB;                       // B operand is immediate
    logic [2:0] funct3;
    logic       instrValid;
    logic       illegal;
  } ctrlE_t;

  typedef struct packed {
    logic       regWrite;
    resultSrc_t resultSrc;
    logic       memRead;
    logic       memWrite;
    logic       instrValid;
    logic       illegal;
  } ctrlM_t;

  typedef struct packed {
    logic       regWrite;
    resultSrc_t resultSrc;
  } ctrlW_t;

  ////////////////////
  // Wishbone classic
  ////////////////////

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    word_t      adr;
    word_t      datW;
    logic [3:0] sel;
  } wbReq_t;

  typedef struct packed {
    logic  ack;
    word_t datR;
  } wbRsp_t;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the ieuCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module ieuCore_tb -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/VieuCore_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

/* tb.f */
hdl/rvPkg.sv
hdl/regFile.sv
hdl/controller.sv
hdl/datapath.sv
hdl/hazardUnit.sv
hdl/lsuWishbone.sv
hdl/ieuCore.sv
verification/ieuCore_checker.sv
verification/ieuCore_tb.sv

/* verification/ieuCore_checker.sv */
// Wishbone master assertions
`timescale 1ns/1ps
`default_nettype none

module ieuCore_checker import rvPkg::*; (
  input logic   clk,
  input logic   arstN,
  input wbReq_t wbOut,
  input wbRsp_t wbIn,
  input logic   memBusyM
);

  stbInCyc: assert property (@(posedge clk) disable iff (!arstN)
    wbOut.stb |-> wbOut.cyc)
    else $error("stb raised outside a bus cycle");

  // Request frozen while the slave waits
  reqHeld: assert property (@(posedge clk) disable iff (!arstN)
    (wbOut.cyc && wbOut.stb && !wbIn.ack) |=>
      ($stable(wbOut.adr) && $stable(wbOut.we) && $stable(wbOut.datW)))
    else $error("request changed before ack");

  cycEnds: assert property (@(posedge clk) disable iff (!arstN)
    (wbOut.cyc && wbIn.ack) |=> !wbOut.cyc)
    else $error("cyc held after ack");

  // Idle bus in reset and on the first cycle out of it
  resetIdle: assert property (@(posedge clk)
    !arstN |-> (!wbOut.cyc && !wbOut.stb && !memBusyM))
    else $error("bus active during reset");

  resetExit: assert property (@(posedge clk)
    $rose(arstN) |-> !wbOut.cyc)
    else $error("cyc high right after reset");

endmodule

bind lsuWishbone ieuCore_checker ieuCore_checker_i (
  .clk      (clk),
  .arstN    (arstN),
  .wbOut    (wbOut),
  .wbIn     (wbIn),
  .memBusyM (memBusyM)
);

`default_nettype wire

/* verification/ieuCore_tb.sv */
// ieuCore testbench
`timescale 1ns/1ps
`default_nettype none

module ieuCore_tb import rvPkg::*; ();

  localparam int     clkPeriod = 20;
  localparam int     romWords  = 256;
  localparam instr_t selfLoop  = 32'h0000006F;   // jal x0, 0 ends the program
  localparam int     opImm = 'h13, opLoad = 'h03, opLui = 'h37, opAuipc = 'h17, opJalr = 'h67;

  logic   clk;
  logic   arstN;
  word_t  instrAdr;
  instr_t instr;
  wbReq_t wbOut;
  wbRsp_t wbIn;
  logic   illegalInstr;

  instr_t      rom [romWords];
  word_t       dmem [256];                     // Bus slave memory
  int          progLen;
  int          storeOff;                       // Next unique store address
  logic [15:0] lfsr;
  word_t       expAdr [$];                     // Expected stores, in order
  word_t       expDat [$];
  int          expAccesses;
  int          storeIdx, accessCount, waitLeft;
  logic        sawIllegal, inCycle;
  logic        expReady = 1'b0;

  ieuCore #(.resetVector('0)) ieuCore_i (.*);

  assign instr = rom[instrAdr[9:2]];           // Combinational ROM

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////
  // Random source and encoders
  ////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsrStep();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic word_t randBits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsrStep()};
    return v;
  endfunction

  function automatic word_t fillWord(input int idx);
    return (word_t'(idx) * 32'h9E3779B9) ^ 32'h5A5A0000;   // Whole index mixed in
  endfunction

  function automatic instr_t encR(input int f7, f3, rd, rs1, rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic instr_t encI(input int op, f3, rd, rs1, imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic instr_t encS(input int rs2, rs1, imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};   // sw
  endfunction

  function automatic instr_t encB(input int f3, rs1, rs2, imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic instr_t encJ(input int rd, imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic instr_t encU(input int op, rd, imm20);
    return {imm20[19:0], rd[4:0], op[6:0]};
  endfunction

  task automatic emit(input instr_t w);
    rom[progLen[7:0]] = w;
    progLen++;
  endtask

  task automatic storeReg(input int r);
    emit(encS(r, 0, storeOff));
    storeOff += 4;
  endtask

  ////////////////////
  // Program generator
  ////////////////////

  task automatic buildProgram();
    int rd, rs2, f3, f7, imm, prevRd, v;
    progLen  = 0;
    storeOff = 'h200;                          // Loads read below, stores land above
    for (int r = 1; r < 8; r++) begin          // Seed x1..x7
      emit(encU(opLui, r, randBits(20)));
      emit(encI(opImm, 0, r, r, randBits(12)));
    end
    prevRd = 1;
    for (int sec = 0; sec < 2; sec++) begin
      for (int k = 0; k < 14; k++) begin       // Chain, rs1 is always the last rd
        rd  = 1 + randBits(3) % 7;
        rs2 = 1 + randBits(3) % 7;
        f3  = randBits(3);
        if (randBits(1)) begin
          f7 = ((f3 == 0 || f3 == 5) && randBits(1)) ? 'h20 : 0;
          emit(encR(f7, f3, rd, prevRd, rs2));
        end else begin
          if (f3 == 1) imm = randBits(5);
          else if (f3 == 5) imm = randBits(5) | (randBits(1) ? 'h400 : 0);   // srli or srai
          else imm = randBits(12);
          emit(encI(opImm, f3, rd, prevRd, imm));
        end
        prevRd = rd;
      end
      for (int r = 1; r < 8; r++) storeReg(r);
      if (sec == 0) emit('0);                  // Unimplemented all-zero word
    end
    emit(encS(3, 0, storeOff));                // sw, lw back, use at once
    emit(encI(opLoad, 2, 9, 0, storeOff));
    storeOff += 4;
    emit(encR(0, 0, 10, 9, 4));
    storeReg(10);
    emit(encI(opLoad, 2, 9, 0, 4 * randBits(7)));   // Preloaded word
    storeReg(9);
    emit(encR(0, 0, 10, 9, 9));
    storeReg(10);
    for (int k = 0; k < 12; k++) begin         // Each branch kind, equal then random
      f3 = (k % 6 < 2) ? k % 6 : k % 6 + 2;
      v  = randBits(12);
      emit(encI(opImm, 0, 11, 0, v));
      emit(encI(opImm, 0, 12, 0, (k < 6) ? v : randBits(12)));
      emit(encI(opImm, 0, 13, 0, k + 1));      // Marker
      emit(encB(f3, 11, 12, 12));
      storeReg(13);                            // Fall-through path only
      emit(encI(opImm, 0, 13, 13, 100));
      storeReg(13);
    end
    emit(encJ(14, 8));
    emit(encI(opImm, 0, 15, 0, 1));            // Skipped by jal
    emit(encU(opAuipc, 16, 0));
    emit(encI(opJalr, 0, 17, 16, 13));         // Odd offset, bit 0 dropped
    emit(encI(opImm, 0, 15, 15, 7));           // Skipped by jalr
    storeReg(14);
    storeReg(17);
    storeReg(15);
    storeReg(16);
    emit(encU(opLui, 18, randBits(20)));
    storeReg(18);
    emit(encU(opAuipc, 19, randBits(20)));
    storeReg(19);
    emit(selfLoop);
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic word_t aluRef(input logic [2:0] f3, input logic alt, input word_t a, b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return word_t'($signed(a) < $signed(b));
      3'd3:    return word_t'(a < b);
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Runs the ROM program in order, fills the expected stores, returns bus accesses
  function automatic int runReference();
    word_t      x [32];
    word_t      mem [256];
    word_t      pc, nextPc, a, b, r, ea, immI, immS, immB, immJ, immU;
    instr_t     w;
    logic [2:0] f3;
    regAdr_t    rd;
    logic       wr, taken;
    int         accesses, steps;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < 256; i++) mem[i] = fillWord(i);
    pc       = '0;
    accesses = 0;
    steps    = 0;
    while (rom[pc[9:2]] != selfLoop && steps < 4 * romWords) begin
      w      = rom[pc[9:2]];
      f3     = w[14:12];
      rd     = w[11:7];
      a      = x[w[19:15]];
      b      = x[w[24:20]];
      immI   = {{20{w[31]}}, w[31:20]};
      immS   = {{20{w[31]}}, w[31:25], w[11:7]};
      immB   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      immJ   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      immU   = {w[31:12], 12'b0};
      wr     = 1'b1;
      r      = '0;
      nextPc = pc + 4;
      case (w[6:0])
        7'h33: r = aluRef(f3, w[30], a, b);
        7'h13: r = aluRef(f3, w[30] & (f3 == 3'd5), a, immI);
        7'h03: begin
          ea = a + immI;
          r  = mem[ea[9:2]];
          accesses++;
        end
        7'h23: begin
          ea = a + immS;
          mem[ea[9:2]] = b;
          expAdr.push_back(ea);
          expDat.push_back(b);
          accesses++;
          wr = 1'b0;
        end
        7'h63: begin
          wr = 1'b0;
          case (f3)
            3'd0:    taken = (a == b);
            3'd1:    taken = (a != b);
            3'd4:    taken = $signed(a) < $signed(b);
            3'd5:    taken = $signed(a) >= $signed(b);
            3'd6:    taken = a < b;
            default: taken = a >= b;
          endcase
          if (taken) nextPc = pc + immB;
        end
        7'h6F: begin
          r      = pc + 4;
          nextPc = pc + immJ;
        end
        7'h67: begin
          r      = pc + 4;
          nextPc = (a + immI) & ~32'd1;
        end
        7'h37:   r = immU;
        7'h17:   r = pc + immU;
        default: wr = 1'b0;                    // Illegal word does nothing
      endcase
      if (wr && rd != 0) x[rd] = r;
      pc = nextPc;
      steps++;
    end
    return accesses;
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic endWithFailure();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      endWithFailure();
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      endWithFailure();
    end
  endtask

  // Wishbone slave, 0 to 3 wait cycles per access
  always @(posedge clk) begin
    #2;
    if (wbIn.ack) begin
      wbIn.ack = 1'b0;
    end else if (wbOut.cyc && wbOut.stb) begin
      if (!inCycle) begin
        waitLeft = randBits(2);
        inCycle  = 1'b1;
      end
      if (waitLeft == 0) begin
        if (wbOut.we) dmem[wbOut.adr[9:2]] = wbOut.datW;
        else wbIn.datR = dmem[wbOut.adr[9:2]];
        wbIn.ack = 1'b1;
        inCycle  = 1'b0;
      end else begin
        waitLeft--;
      end
    end
  end

  // Bus and illegal flag sampled mid-cycle
  always @(negedge clk) begin
    if (arstN) begin
      if (illegalInstr) sawIllegal = 1'b1;
      if (wbOut.cyc && wbOut.stb && wbIn.ack) begin
        accessCount++;
        checkWord("wbOut.sel", word_t'(wbOut.sel), 32'h0000000f);   // Whole words only
        if (wbOut.we && storeIdx >= expAdr.size()) begin
          $display("store at %0t beyond the expected sequence", $time);
          endWithFailure();
        end else if (wbOut.we) begin
          checkWord("wbOut.adr", wbOut.adr, expAdr[storeIdx]);
          checkWord("wbOut.datW", wbOut.datW, expDat[storeIdx]);
          storeIdx++;
        end
      end
    end
  end

  initial begin
    wait (expReady);
    #(40 * progLen * clkPeriod);
    $display("timeout, only %0d of %0d stores seen", storeIdx, expAdr.size());
    endWithFailure();
  end

  initial begin
    arstN       = 1'b1;
    wbIn        = '0;
    lfsr        = 16'd24665;
    storeIdx    = 0;
    accessCount = 0;
    waitLeft    = 0;
    sawIllegal  = 1'b0;
    inCycle     = 1'b0;
    for (int i = 0; i < 256; i++) begin
      rom[i[7:0]]  = selfLoop;
      dmem[i[7:0]] = fillWord(i);
    end
    buildProgram();
    expAccesses = runReference();
    expReady    = 1'b1;
    #2 arstN = 1'b0;
    repeat (8) @(posedge clk);
    #2 arstN = 1'b1;
    wait (storeIdx == expAdr.size());
    repeat (30) @(posedge clk);                // Catch late or repeated accesses
    checkBit("illegalInstr seen", sawIllegal, 1'b1);
    checkWord("bus access count", word_t'(accessCount), word_t'(expAccesses));
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
